// ==== verilog/ddr_cmd_pkg.sv ====
package ddr_cmd_pkg;

    // raw command pins as seen on the dimm edge connector
    typedef struct packed {
        logic        cs_n;   // chip select, active low
        logic        act_n;  // activate, active low
        logic [16:0] addr;   // row or column, [16:14] double as ras/cas/we
        logic [1:0]  bg;     // bank group, only bit 0 is modeled
        logic [1:0]  ba;     // bank address
    } ddr_cmd_bus_t;

    // address bit positions with a second meaning
    localparam int ADDR_RAS = 16;
    localparam int ADDR_CAS = 15;
    localparam int ADDR_WE  = 14;
    localparam int ADDR_AP  = 10;  // auto-precharge on rd/wr

    // decoded per-bank command, CMD_NONE must stay at zero
    typedef enum logic [2:0] {
        CMD_NONE,
        CMD_ACT,
        CMD_PRE,
        CMD_RD,
        CMD_RDA,
        CMD_WR,
        CMD_WRA
    } bank_cmd_e;

    // one registered request, fanned out to every bank of every chip
    typedef struct packed {
        bank_cmd_e   cmd;
        logic [2:0]  bank;  // {bg[0], ba}
        logic [16:0] row;   // meaningful on CMD_ACT
        logic [9:0]  col;   // meaningful on rd/wr
    } bank_req_t;

endpackage

// ==== verilog/ddr_geom_pkg.sv ====
package ddr_geom_pkg;

    localparam int DIMM_WIDTH     = 64;  // data bus across all chips
    localparam int BURST_LEN      = 8;   // BL8 only
    localparam int BANKS_PER_CHIP = 8;   // bg[0] x ba
    localparam int LANE_WIDTH     = 16;  // widest chip lane, x4/x8 parts zero extend

    typedef logic [DIMM_WIDTH-1:0] dimm_data_t;
    typedef logic [LANE_WIDTH-1:0] lane_t;

    // one staged write beat of a single chip
    typedef struct packed {
        logic       valid;
        logic [2:0] bank;  // target bank of the running burst
        logic [2:0] beat;  // 0..7 within the burst
        lane_t      data;
        lane_t      mask;  // 1 keeps the old cell bit
    } wr_beat_t;

endpackage

// ==== verilog/ddr_cmd_decoder.sv ====
`timescale 1ns/10ps

module ddr_cmd_decoder
    import ddr_cmd_pkg::*;
(
    input  logic         clk_in,
    input  logic         rst_N_in,
    input  ddr_cmd_bus_t cmd,
    output bank_req_t    req
);
    bank_cmd_e  cmd_dec;   // combinational decode of this edge's pins
    logic [2:0] rcw;       // {ras, cas, we}
    logic       ap;        // auto-precharge flag

    assign rcw = {cmd.addr[ADDR_RAS], cmd.addr[ADDR_CAS], cmd.addr[ADDR_WE]};
    assign ap  = cmd.addr[ADDR_AP];

    always_comb begin
        cmd_dec = CMD_NONE;
        if (!cmd.cs_n) begin  // deselected -> nop
            if (!cmd.act_n) begin
                cmd_dec = CMD_ACT;  // row comes from addr
            end else begin
                case (rcw)
                    3'b010: begin
                        if (!ap) begin
                            cmd_dec = CMD_PRE;  // single bank only, pre-all not modeled
                        end
                    end
                    3'b100: cmd_dec = ap ? CMD_WRA : CMD_WR;
                    3'b101: cmd_dec = ap ? CMD_RDA : CMD_RD;
                    default: cmd_dec = CMD_NONE;  // refresh, mrs, zq etc. ignored
                endcase
            end
        end
    end

    // one cycle of latency, banks see req on the edge after sampling
    always_ff @(posedge clk_in) begin
        if (rst_N_in) begin
            req.cmd <= CMD_NONE;
        end else begin
            req.cmd  <= cmd_dec;
            req.bank <= {cmd.bg[0], cmd.ba};  // upper bank group bit dropped
            req.row  <= cmd.addr;
            req.col  <= cmd.addr[9:0];
        end
    end

endmodule

// ==== verilog/sdram_bank.sv ====
`timescale 1ns/10ps

module sdram_bank
    import ddr_cmd_pkg::*;
    import ddr_geom_pkg::*;
#(
    parameter int CAS_LATENCY = 22,
    parameter int ACT_LATENCY = 8,   // at least 2
    parameter int PRE_LATENCY = 5,   // at least 2
    parameter int ROW_BITS    = 8,
    parameter int COL_BITS    = 4,
    parameter int CHIP_WIDTH  = 16,
    parameter int BANK_ID     = 0
) (
    input  logic                  clk_in,
    input  logic                  rst_N_in,
    input  bank_req_t             req,
    input  wr_beat_t              wr_beat,
    output logic [CHIP_WIDTH-1:0] rd_data,
    output logic                  rd_valid
);
    localparam int ROWS  = 1 << ROW_BITS;
    localparam int COLS  = 1 << COL_BITS;
    localparam int CNT_W = $clog2(CAS_LATENCY + ACT_LATENCY + PRE_LATENCY + BURST_LEN);

    // counter reloads, req reaches us one edge after the command edge
    localparam logic [CNT_W-1:0] ACT_WAIT = CNT_W'(ACT_LATENCY - 2);
    localparam logic [CNT_W-1:0] PRE_WAIT = CNT_W'(PRE_LATENCY - 2);
    localparam logic [CNT_W-1:0] WR_WAIT  = CNT_W'(BURST_LEN - 2);  // beats 1..7
    localparam logic [CNT_W-1:0] RD_WAIT  = CNT_W'(CAS_LATENCY + BURST_LEN - 4);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ACTIVATING,
        ST_ACTIVE,
        ST_READING,
        ST_WRITING,
        ST_PRECHARGING
    } bank_state_e;

    typedef logic [COLS-1:0][CHIP_WIDTH-1:0] row_t;

    row_t                  cells [ROWS];  // cell array, one whole row per entry
    row_t                  row_buf;       // sense amps
    logic [ROW_BITS-1:0]   row_q;         // open row, target of write-back
    logic [COL_BITS-1:0]   col_q;         // start column of current burst
    logic [COL_BITS-1:0]   wcol;
    logic [COL_BITS-1:0]   rcol;
    logic [CHIP_WIDTH-1:0] wdata;
    logic [CHIP_WIDTH-1:0] wmask;

    bank_state_e      state;
    logic [CNT_W-1:0] cnt;       // single latency counter, counts down
    logic             auto_pre;  // close row after the burst
    logic             hit;
    logic             act_go, pre_go, rd_go, wr_go;
    logic             beat_hit;
    logic             burst_on;  // read beat goes out this edge

    // start column with the low three bits advanced, upper bits fixed
    function automatic logic [COL_BITS-1:0] wrap_col(input logic [COL_BITS-1:0] base,
                                                     input logic [2:0] beat);
        logic [COL_BITS-1:0] c;
        c      = base;
        c[2:0] = base[2:0] + beat;
        return c;
    endfunction

    assign hit    = (req.bank == 3'(BANK_ID));
    assign act_go = hit && (state == ST_IDLE) && (req.cmd == CMD_ACT);
    assign pre_go = hit && (state == ST_ACTIVE) && (req.cmd == CMD_PRE);
    assign rd_go  = hit && (state == ST_ACTIVE) && (req.cmd == CMD_RD || req.cmd == CMD_RDA);
    assign wr_go  = hit && (state == ST_ACTIVE) && (req.cmd == CMD_WR || req.cmd == CMD_WRA);

    assign beat_hit = wr_beat.valid && (wr_beat.bank == 3'(BANK_ID));
    assign wdata    = wr_beat.data[CHIP_WIDTH-1:0];
    assign wmask    = wr_beat.mask[CHIP_WIDTH-1:0];
    assign wcol     = wrap_col(wr_go ? req.col[COL_BITS-1:0] : col_q, wr_beat.beat);  // beat 0 uses req

    // last BURST_LEN counts of the read wait are the data beats
    assign burst_on = (state == ST_READING) && (cnt < CNT_W'(BURST_LEN));
    assign rcol     = wrap_col(col_q, 3'(BURST_LEN - 1) - cnt[2:0]);

    always_ff @(posedge clk_in) begin
        if (rst_N_in) begin
            state    <= ST_IDLE;
            cnt      <= '0;
            auto_pre <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= burst_on;
            case (state)
                ST_IDLE: begin
                    if (act_go) begin
                        state <= ST_ACTIVATING;
                        cnt   <= ACT_WAIT;
                    end
                end
                ST_ACTIVATING, ST_PRECHARGING: begin
                    if (cnt == '0) begin
                        state <= (state == ST_ACTIVATING) ? ST_ACTIVE : ST_IDLE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                ST_ACTIVE: begin
                    auto_pre <= (req.cmd == CMD_RDA) || (req.cmd == CMD_WRA);
                    if (pre_go) begin
                        state <= ST_PRECHARGING;
                        cnt   <= PRE_WAIT;
                    end else if (rd_go) begin
                        state <= ST_READING;
                        cnt   <= RD_WAIT;
                    end else if (wr_go) begin
                        state <= ST_WRITING;
                        cnt   <= WR_WAIT;
                    end
                end
                ST_READING, ST_WRITING: begin
                    if (cnt == '0) begin  // last beat on this edge
                        state <= auto_pre ? ST_PRECHARGING : ST_ACTIVE;
                        cnt   <= PRE_WAIT;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // array, row buffer and read lane
    always_ff @(posedge clk_in) begin
        if (act_go) begin
            row_q   <= req.row[ROW_BITS-1:0];
            row_buf <= cells[req.row[ROW_BITS-1:0]];  // open row
        end
        if (rd_go || wr_go) begin
            col_q <= req.col[COL_BITS-1:0];
        end
        if (beat_hit) begin
            row_buf[wcol] <= (row_buf[wcol] & wmask) | (wdata & ~wmask);  // mask 1 keeps old
        end
        if (state == ST_PRECHARGING && cnt == '0) begin
            cells[row_q] <= row_buf;  // write-back closes the row
        end
        rd_data <= burst_on ? row_buf[rcol] : '0;  // zero keeps the chip or-merge clean
    end

endmodule

// ==== verilog/ddr4_chip.sv ====
`timescale 1ns/10ps

module ddr4_chip
    import ddr_cmd_pkg::*;
    import ddr_geom_pkg::*;
#(
    parameter int CAS_LATENCY = 22,
    parameter int ACT_LATENCY = 8,
    parameter int PRE_LATENCY = 5,
    parameter int ROW_BITS    = 8,
    parameter int COL_BITS    = 4,
    parameter int CHIP_WIDTH  = 16
) (
    input  logic                  clk_in,
    input  logic                  rst_N_in,
    input  bank_req_t             req,
    input  logic [CHIP_WIDTH-1:0] dq_in,
    input  logic [CHIP_WIDTH-1:0] dqm,
    output logic [CHIP_WIDTH-1:0] dq_out,
    output logic                  dq_valid
);
    logic [CHIP_WIDTH-1:0] dq_q;        // data delayed to line up with req
    logic [CHIP_WIDTH-1:0] dqm_q;
    logic                  wr_start;    // req carries a write this cycle
    logic                  burst_on;    // beats 1..7 still to come
    logic [2:0]            beat_cnt;
    logic [2:0]            burst_bank;  // held for the rest of the burst
    wr_beat_t              wr_beat;

    logic [BANKS_PER_CHIP-1:0][CHIP_WIDTH-1:0] bank_data;
    logic [BANKS_PER_CHIP-1:0]                 bank_valid;

    assign wr_start = (req.cmd == CMD_WR) || (req.cmd == CMD_WRA);

    // beat 0 was on the pins at the command edge, one flop aligns it with req
    always_ff @(posedge clk_in) begin
        dq_q  <= dq_in;
        dqm_q <= dqm;
    end

    // eight-beat capture counter
    always_ff @(posedge clk_in) begin
        if (rst_N_in) begin
            burst_on   <= 1'b0;
            beat_cnt   <= '0;
            burst_bank <= '0;
        end else if (wr_start) begin
            burst_on   <= 1'b1;
            beat_cnt   <= 3'd1;  // beat 0 goes out with req itself
            burst_bank <= req.bank;
        end else if (burst_on) begin
            beat_cnt <= beat_cnt + 3'd1;
            if (beat_cnt == 3'(BURST_LEN - 1)) begin
                burst_on <= 1'b0;  // last beat out
            end
        end
    end

    always_comb begin
        wr_beat.valid = wr_start || burst_on;
        wr_beat.bank  = wr_start ? req.bank : burst_bank;
        wr_beat.beat  = wr_start ? 3'd0 : beat_cnt;
        wr_beat.data  = lane_t'(dq_q);   // zero extend narrow chips
        wr_beat.mask  = lane_t'(dqm_q);
    end

    for (genvar b = 0; b < BANKS_PER_CHIP; b++) begin : g_bank
        sdram_bank #(
            .CAS_LATENCY (CAS_LATENCY),
            .ACT_LATENCY (ACT_LATENCY),
            .PRE_LATENCY (PRE_LATENCY),
            .ROW_BITS    (ROW_BITS),
            .COL_BITS    (COL_BITS),
            .CHIP_WIDTH  (CHIP_WIDTH),
            .BANK_ID     (b)
        ) u_bank (
            .clk_in   (clk_in),
            .rst_N_in (rst_N_in),
            .req      (req),
            .wr_beat  (wr_beat),
            .rd_data  (bank_data[b]),
            .rd_valid (bank_valid[b])
        );
    end

    // idle banks drive zero, so a plain or merges the lanes
    always_comb begin
        dq_out   = '0;
        dq_valid = 1'b0;
        for (int b = 0; b < BANKS_PER_CHIP; b++) begin
            dq_out   = dq_out | bank_data[b];
            dq_valid = dq_valid | bank_valid[b];
        end
    end

endmodule

// ==== verilog/ddr4_dimm.sv ====
`timescale 1ns/10ps

module ddr4_dimm
    import ddr_cmd_pkg::*;
    import ddr_geom_pkg::*;
#(
    parameter int CAS_LATENCY = 22,  // cycles from rd command edge to first beat
    parameter int ACT_LATENCY = 8,   // cycles until an opened row is usable
    parameter int PRE_LATENCY = 5,   // cycles until the row buffer is written back
    parameter int ROW_BITS    = 8,   // log2 rows per bank
    parameter int COL_BITS    = 4,   // log2 columns per row, at least 3
    parameter int CHIP_WIDTH  = 16   // lane width of one chip
) (
    input  logic         clk_in,
    input  logic         rst_N_in,
    input  ddr_cmd_bus_t cmd,
    input  dimm_data_t   dq_in,
    input  dimm_data_t   dqm,
    output dimm_data_t   dq_out,
    output logic         dq_valid
);
    localparam int NUM_CHIPS = DIMM_WIDTH / CHIP_WIDTH;

    bank_req_t            req;         // decoded once, shared by all chips
    logic [NUM_CHIPS-1:0] chip_valid;

    // all chips see the same pins, so decode only once here
    ddr_cmd_decoder u_decoder (
        .clk_in   (clk_in),
        .rst_N_in (rst_N_in),
        .cmd      (cmd),
        .req      (req)
    );

    for (genvar c = 0; c < NUM_CHIPS; c++) begin : g_chip
        ddr4_chip #(
            .CAS_LATENCY (CAS_LATENCY),
            .ACT_LATENCY (ACT_LATENCY),
            .PRE_LATENCY (PRE_LATENCY),
            .ROW_BITS    (ROW_BITS),
            .COL_BITS    (COL_BITS),
            .CHIP_WIDTH  (CHIP_WIDTH)
        ) u_chip (
            .clk_in   (clk_in),
            .rst_N_in (rst_N_in),
            .req      (req),
            .dq_in    (dq_in[c*CHIP_WIDTH +: CHIP_WIDTH]),  // this chip's byte lanes
            .dqm      (dqm[c*CHIP_WIDTH +: CHIP_WIDTH]),
            .dq_out   (dq_out[c*CHIP_WIDTH +: CHIP_WIDTH]),
            .dq_valid (chip_valid[c])
        );
    end

    // chips run in lockstep, chip 0 speaks for the dimm
    assign dq_valid = chip_valid[0];

endmodule

// ==== sim/ddr4_dimm_properties.sv ====
`timescale 1ns/10ps

module ddr4_dimm_properties
    import ddr_cmd_pkg::*;
#(
    parameter int CAS_LATENCY = 22
) (
    input logic         clk_in,
    input logic         rst_N_in,
    input ddr_cmd_bus_t cmd,
    input logic         dq_valid
);
    logic rd_cmd;      // rd or rda on the pins this edge
    logic rd_seen;     // some read sampled since reset
    int   fail_count;  // failed property attempts

    // cs low, act high, ras/cas/we = 101
    assign rd_cmd = !cmd.cs_n && cmd.act_n && (cmd.addr[16:14] == 3'b101);

    always_ff @(posedge clk_in) begin
        if (rst_N_in) begin
            rd_seen <= 1'b0;
        end else if (rd_cmd) begin
            rd_seen <= 1'b1;
        end
    end

    // synchronous reset clears the lane flag on the next edge
    reset_clears_valid: assert property (@(posedge clk_in) rst_N_in |=> !dq_valid)
        else begin
            fail_count++;
            $error("dq_valid still high after a reset cycle");
        end

    quiet_until_read: assert property (@(posedge clk_in) disable iff (rst_N_in)
        !rd_seen |-> !dq_valid)
        else begin
            fail_count++;
            $error("dq_valid high before any read was issued");
        end

    // first beat sampled exactly CAS_LATENCY edges after the read edge
    valid_after_cas: assert property (@(posedge clk_in) disable iff (rst_N_in)
        $rose(dq_valid) |-> $past(rd_cmd, CAS_LATENCY))
        else begin
            fail_count++;
            $error("dq_valid rose without a read CAS_LATENCY cycles earlier");
        end

    burst_of_eight: assert property (@(posedge clk_in) disable iff (rst_N_in)
        $rose(dq_valid) |-> dq_valid [*8] ##1 !dq_valid)
        else begin
            fail_count++;
            $error("dq_valid run is not eight cycles long");
        end

endmodule

bind ddr4_dimm ddr4_dimm_properties #(
    .CAS_LATENCY (CAS_LATENCY)
) u_properties (
    .clk_in   (clk_in),
    .rst_N_in (rst_N_in),
    .cmd      (cmd),
    .dq_valid (dq_valid)
);

// ==== sim/ddr4_dimm_tb.sv ====
`timescale 1ns/10ps

module ddr4_dimm_tb
    import ddr_cmd_pkg::*;
    import ddr_geom_pkg::*;
();
    localparam int CAS_LAT    = 6;
    localparam int ACT_LAT    = 3;
    localparam int PRE_LAT    = 2;
    localparam int ROW_BITS   = 8;
    localparam int COL_BITS   = 4;
    localparam int RD_TIMEOUT = 4 * CAS_LAT + 10;  // cycles allowed before first beat

    logic         clk_in;
    logic         rst_N_in;
    ddr_cmd_bus_t cmd;
    dimm_data_t   dq_in;
    dimm_data_t   dqm;
    dimm_data_t   dq_out;
    logic         dq_valid;

    dimm_data_t          shadow [BANKS_PER_CHIP][1 << ROW_BITS][1 << COL_BITS];  // expected cells
    logic [ROW_BITS-1:0] open_row [BANKS_PER_CHIP];
    logic [31:0]         seed;
    logic                rd_started;  // first read issued
    int                  n_checks;
    int                  n_value_err;
    int                  n_other_err;
    int                  n_prop_err;  // bound property failures

    ddr4_dimm #(
        .CAS_LATENCY (CAS_LAT),
        .ACT_LATENCY (ACT_LAT),
        .PRE_LATENCY (PRE_LAT),
        .ROW_BITS    (ROW_BITS),
        .COL_BITS    (COL_BITS),
        .CHIP_WIDTH  (16)
    ) DUT (
        .clk_in   (clk_in),
        .rst_N_in (rst_N_in),
        .cmd      (cmd),
        .dq_in    (dq_in),
        .dqm      (dqm),
        .dq_out   (dq_out),
        .dq_valid (dq_valid)
    );

    initial begin
        clk_in = 1'b0;
        forever #20 clk_in = ~clk_in;  // 40 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // column of beat k, low three bits wrap inside the block of eight
    function automatic logic [COL_BITS-1:0] beat_col(input logic [COL_BITS-1:0] col,
                                                     input logic [2:0] k);
        logic [COL_BITS-1:0] c;
        c      = col;
        c[2:0] = col[2:0] + k;
        return c;
    endfunction

    function automatic ddr_cmd_bus_t make_cmd(input logic cs_n, input logic act_n,
                                              input logic [16:0] addr, input logic [2:0] bank);
        ddr_cmd_bus_t c;
        c.cs_n  = cs_n;
        c.act_n = act_n;
        c.addr  = addr;
        c.bg    = {1'b0, bank[2]};  // bank index msb rides on bg[0]
        c.ba    = bank[1:0];
        return c;
    endfunction

    function automatic ddr_cmd_bus_t nop_cmd();
        return make_cmd(1'b1, 1'b1, 17'd0, 3'd0);  // deselect
    endfunction

    task automatic next_rand(output logic [63:0] v);
        seed      = xorshift32(seed);
        v[63:32]  = seed;
        seed      = xorshift32(seed);
        v[31:0]   = seed;
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk_in);
    endtask

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
        n_checks++;
        assert (got === exp) else begin
            n_value_err++;
            $display("Fail: %s expected %h got %h at %0t", name, exp, got, $time);
        end
    endtask

    task automatic activate(input logic [2:0] bank, input logic [ROW_BITS-1:0] row);
        @(negedge clk_in);
        cmd            = make_cmd(1'b0, 1'b0, 17'(row), bank);
        open_row[bank] = row;
        @(negedge clk_in);
        cmd = nop_cmd();
        idle(ACT_LAT);  // row usable ACT_LAT cycles later
    endtask

    task automatic precharge(input logic [2:0] bank);
        @(negedge clk_in);
        cmd = make_cmd(1'b0, 1'b1, {3'b010, 14'd0}, bank);  // a10 low, single bank
        @(negedge clk_in);
        cmd = nop_cmd();
        idle(PRE_LAT);
    endtask

    task automatic write_burst(input logic [2:0] bank, input logic [COL_BITS-1:0] col,
                               input logic ap, input logic masked);
        dimm_data_t          d;
        dimm_data_t          m;
        logic [COL_BITS-1:0] c;
        for (int k = 0; k < BURST_LEN; k++) begin
            next_rand(d);
            next_rand(m);
            if (!masked) begin
                m = '0;
            end
            c = beat_col(col, 3'(k));
            @(negedge clk_in);
            cmd   = (k == 0) ? make_cmd(1'b0, 1'b1, {3'b100, 3'b000, ap, 10'(col)}, bank)
                             : nop_cmd();
            dq_in = d;  // beat 0 travels with the command
            dqm   = m;
            shadow[bank][open_row[bank]][c] = (shadow[bank][open_row[bank]][c] & m) | (d & ~m);
        end
        @(negedge clk_in);
        dq_in = '0;
        dqm   = '0;
        if (ap) begin
            idle(BURST_LEN + PRE_LAT);  // bank closes itself
        end
    endtask

    task automatic read_burst(input logic [2:0] bank, input logic [COL_BITS-1:0] col,
                              input logic ap);
        int cycles;
        @(negedge clk_in);
        cmd        = make_cmd(1'b0, 1'b1, {3'b101, 3'b000, ap, 10'(col)}, bank);
        rd_started = 1'b1;
        @(negedge clk_in);
        cmd    = nop_cmd();
        cycles = 1;
        while (dq_valid !== 1'b1 && cycles < RD_TIMEOUT) begin
            @(negedge clk_in);
            cycles++;
        end
        if (dq_valid !== 1'b1) begin
            n_other_err++;
            $display("no read data from bank %0d within %0d cycles", bank, RD_TIMEOUT);
            return;
        end
        // seen half a cycle before the CAS edge
        check_value("dq_valid latency", 64'(CAS_LAT), 64'(cycles));
        for (int k = 0; k < BURST_LEN; k++) begin
            if (k > 0) begin
                @(negedge clk_in);
                check_value("dq_valid", 64'd1, 64'(dq_valid));
            end
            check_value("dq_out", shadow[bank][open_row[bank]][beat_col(col, 3'(k))], dq_out);
        end
        @(negedge clk_in);
        check_value("dq_valid", 64'd0, 64'(dq_valid));  // burst is exactly eight
        if (ap) begin
            idle(PRE_LAT + 1);
        end
    endtask

    // quiet lanes before the first read, zero data whenever not valid
    always @(negedge clk_in) begin
        if (rst_N_in === 1'b0) begin
            if (!rd_started) begin
                check_value("dq_valid", 64'd0, 64'(dq_valid));
            end
            if (dq_valid !== 1'b1) begin
                check_value("dq_out", 64'd0, dq_out);
            end
        end
    end

    initial begin
        dimm_data_t          r;
        logic [2:0]          b;
        logic [ROW_BITS-1:0] row;
        logic [COL_BITS-1:0] col;
        rst_N_in    = 1'b1;  // reset is active high
        cmd         = nop_cmd();
        dq_in       = '0;
        dqm         = '0;
        seed        = 32'h983c_00f4;
        rd_started  = 1'b0;
        n_checks    = 0;
        n_value_err = 0;
        n_other_err = 0;
        n_prop_err  = 0;
        repeat (3) @(negedge clk_in);
        rst_N_in = 1'b0;
        idle(8);  // lanes must stay quiet

        activate(3'd0, 8'd5);
        write_burst(3'd0, 4'd0, 1'b0, 1'b0);  // full write, all four chips
        read_burst(3'd0, 4'd0, 1'b0);
        write_burst(3'd0, 4'd0, 1'b0, 1'b1);  // partial dqm over old data
        read_burst(3'd0, 4'd0, 1'b0);
        write_burst(3'd0, 4'd11, 1'b0, 1'b0); // wraps 11..15, 8..10
        read_burst(3'd0, 4'd14, 1'b0);
        read_burst(3'd0, 4'd5, 1'b0);

        activate(3'd3, 8'd9);
        write_burst(3'd3, 4'd2, 1'b1, 1'b0);  // wra closes row 9
        activate(3'd6, 8'd9);
        write_burst(3'd6, 4'd6, 1'b0, 1'b0);  // other bank meanwhile
        activate(3'd3, 8'd20);
        write_burst(3'd3, 4'd2, 1'b0, 1'b0);
        precharge(3'd3);
        activate(3'd3, 8'd9);
        read_burst(3'd3, 4'd2, 1'b1);         // rda
        read_burst(3'd6, 4'd6, 1'b0);
        precharge(3'd6);

        precharge(3'd0);                      // close row 5 by pre
        activate(3'd0, 8'd7);
        write_burst(3'd0, 4'd0, 1'b0, 1'b0);
        precharge(3'd0);
        activate(3'd0, 8'd5);
        read_burst(3'd0, 4'd0, 1'b1);

        repeat (4) begin
            next_rand(r);
            b   = r[2:0];
            row = r[10:3];
            col = r[14:11];
            activate(b, row);
            write_burst(b, col, 1'b0, 1'b0);
            write_burst(b, col, 1'b0, 1'b1);
            read_burst(b, {col[3], r[17:15]}, 1'b0);  // same block of eight
            precharge(b);
        end

        idle(4);
        n_prop_err = DUT.u_properties.fail_count;
        $display("checks %0d, value errors %0d, other errors %0d, property errors %0d",
                 n_checks, n_value_err, n_other_err, n_prop_err);
        if (n_value_err == 0 && n_other_err == 0 && n_prop_err == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
verilog/ddr_cmd_pkg.sv
verilog/ddr_geom_pkg.sv
verilog/ddr_cmd_decoder.sv
verilog/sdram_bank.sv
verilog/ddr4_chip.sv
verilog/ddr4_dimm.sv
sim/ddr4_dimm_properties.sv
sim/ddr4_dimm_tb.sv
